// ==== aib_adapt_pkg.sv ====
// Shared definitions for the die-to-die adapter channel
// Register map, readback masks, field positions and stream types
`default_nettype none

package aib_adapt_pkg;

   typedef logic [6:0]  csr_addr_t;
   typedef logic [31:0] csr_data_t;
   typedef logic [3:0]  byte_en_t;
   typedef logic [31:0] lane_word_t;
   typedef logic [2:0]  dly_t;

   // Register word addresses
   localparam csr_addr_t ADDR_RX_0 = 7'h08;
   localparam csr_addr_t ADDR_RX_1 = 7'h10;
   localparam csr_addr_t ADDR_TX_0 = 7'h18;
   localparam csr_addr_t ADDR_TX_1 = 7'h1c;

   // Implemented bits per register, all others read as zero
   localparam csr_data_t RD_MASK_RX_0 = 32'h0700_0002;
   localparam csr_data_t RD_MASK_RX_1 = 32'h0000_0007;
   localparam csr_data_t RD_MASK_TX_0 = 32'hf0e0_0002;
   localparam csr_data_t RD_MASK_TX_1 = 32'h0000_c000;

   // Field positions
   localparam int CFG_ENABLE_BIT  = 1;
   localparam int TX0_DELAY_LSB   = 21;
   localparam int TX0_IDLE_LSB    = 28;
   localparam int TX1_REVERSE_BIT = 15;
   localparam int TX1_INVERT_BIT  = 14;
   localparam int RX0_DELAY_LSB   = 24;
   localparam int RX1_INVERT_BIT  = 2;
   localparam int RX1_ROTATE_LSB  = 0;

   typedef struct packed {
      logic       enable;
      dly_t       delay;
      logic [3:0] idle_nibble;
      logic       bit_reverse;
      logic       invert;
   } tx_cfg_t;

   typedef struct packed {
      logic       enable;
      dly_t       delay;
      logic       invert;
      logic [1:0] byte_rotate;
   } rx_cfg_t;

   typedef struct packed {
      logic       valid;
      lane_word_t data;
   } lane_beat_t;

endpackage

`default_nettype wire

// ==== aib_avmm_adapt_csr.sv ====
// Configuration registers for the adapter channel
// Byte-enabled writes, one-cycle registered reads of the implemented fields,
// and continuous unpacking into the tx and rx configuration structs
`default_nettype none

module aib_avmm_adapt_csr (
   input  wire logic                     clk,
   input  wire logic                     reset_n,
   input  wire aib_adapt_pkg::csr_addr_t address,
   input  wire aib_adapt_pkg::csr_data_t writedata,
   input  wire aib_adapt_pkg::byte_en_t  byteenable,
   input  wire logic                     read,
   input  wire logic                     write,
   output aib_adapt_pkg::csr_data_t      readdata,
   output logic                          readdatavalid,
   output aib_adapt_pkg::tx_cfg_t        tx_cfg,
   output aib_adapt_pkg::rx_cfg_t        rx_cfg
);

   localparam int NUM_REGS = 4;
   localparam int REG_RX_0 = 0;
   localparam int REG_RX_1 = 1;
   localparam int REG_TX_0 = 2;
   localparam int REG_TX_1 = 3;
   localparam int DLY_W    = $bits(aib_adapt_pkg::dly_t);

   localparam aib_adapt_pkg::csr_addr_t REG_ADDR [NUM_REGS] = '{
      aib_adapt_pkg::ADDR_RX_0, aib_adapt_pkg::ADDR_RX_1,
      aib_adapt_pkg::ADDR_TX_0, aib_adapt_pkg::ADDR_TX_1};

   localparam aib_adapt_pkg::csr_data_t REG_MASK [NUM_REGS] = '{
      aib_adapt_pkg::RD_MASK_RX_0, aib_adapt_pkg::RD_MASK_RX_1,
      aib_adapt_pkg::RD_MASK_TX_0, aib_adapt_pkg::RD_MASK_TX_1};

   aib_adapt_pkg::csr_data_t csr_q [NUM_REGS];
   aib_adapt_pkg::csr_data_t lane_mask;
   aib_adapt_pkg::csr_data_t rdata_comb;
   logic [NUM_REGS-1:0]      reg_hit;

   // Lane 3 reaches only the top nibble, bits 27:24 stay at reset value
   assign lane_mask = {{4{byteenable[3]}}, 4'h0, {8{byteenable[2]}},
                       {8{byteenable[1]}}, {8{byteenable[0]}}};

   // Address decode and masked read mux
   always_comb begin
      rdata_comb = '0;
      for (int i = 0; i < NUM_REGS; i++) begin
         reg_hit[i] = (address == REG_ADDR[i]);
         if (reg_hit[i]) begin
            rdata_comb = rdata_comb | (csr_q[i] & REG_MASK[i]);
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_REGS; i++) begin
         if (!reset_n) begin
            csr_q[i] <= '0;
         end else if (write && reg_hit[i]) begin
            csr_q[i] <= (csr_q[i] & ~lane_mask) | (writedata & lane_mask);
         end
      end
   end

   // Read data always comes back on the following cycle
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         readdata      <= '0;
         readdatavalid <= 1'b0;
      end else begin
         readdata      <= read ? rdata_comb : '0;
         readdatavalid <= read;
      end
   end

   always_comb begin
      tx_cfg.enable      = csr_q[REG_TX_0][aib_adapt_pkg::CFG_ENABLE_BIT];
      tx_cfg.delay       = csr_q[REG_TX_0][aib_adapt_pkg::TX0_DELAY_LSB +: DLY_W];
      tx_cfg.idle_nibble = csr_q[REG_TX_0][aib_adapt_pkg::TX0_IDLE_LSB +: 4];
      tx_cfg.bit_reverse = csr_q[REG_TX_1][aib_adapt_pkg::TX1_REVERSE_BIT];
      tx_cfg.invert      = csr_q[REG_TX_1][aib_adapt_pkg::TX1_INVERT_BIT];
      rx_cfg.enable      = csr_q[REG_RX_0][aib_adapt_pkg::CFG_ENABLE_BIT];
      rx_cfg.delay       = csr_q[REG_RX_0][aib_adapt_pkg::RX0_DELAY_LSB +: DLY_W];
      rx_cfg.invert      = csr_q[REG_RX_1][aib_adapt_pkg::RX1_INVERT_BIT];
      rx_cfg.byte_rotate = csr_q[REG_RX_1][aib_adapt_pkg::RX1_ROTATE_LSB +: 2];
   end

   a_rvalid_follows_read: assert property (
      @(posedge clk) disable iff (!reset_n)
      readdatavalid == $past(read));

   // Master side contract
   a_no_read_write_overlap: assert property (
      @(posedge clk) disable iff (!reset_n)
      !(read && write));

endmodule

`default_nettype wire

// ==== aib_adapt_tx.sv ====
// Transmit adapter, core word to pad word
// Optional inversion and bit reversal, then a tapped delay line;
// idle nibble pattern on the pad whenever no valid beat is out
`default_nettype none

module aib_adapt_tx #(
   parameter int MAX_DELAY = 7
) (
   input  wire logic                      clk,
   input  wire logic                      reset_n,
   input  wire aib_adapt_pkg::tx_cfg_t    cfg,
   input  wire aib_adapt_pkg::lane_beat_t tx_in,
   output aib_adapt_pkg::lane_beat_t      tx_out
);

   localparam int DEPTH = MAX_DELAY + 1;

   aib_adapt_pkg::lane_word_t inv_word;
   aib_adapt_pkg::lane_word_t in_word;
   aib_adapt_pkg::lane_word_t idle_word;
   aib_adapt_pkg::lane_word_t data_q [DEPTH];
   logic [MAX_DELAY:0]        vld_q;
   aib_adapt_pkg::dly_t       tap;
   logic                      out_valid;

   always_comb begin
      inv_word = cfg.invert ? ~tx_in.data : tx_in.data;
      in_word  = cfg.bit_reverse ? {<<{inv_word}} : inv_word;
   end

   // Settings beyond the line depth use the last stage
   assign tap = (cfg.delay > MAX_DELAY) ? aib_adapt_pkg::dly_t'(MAX_DELAY) : cfg.delay;

   assign idle_word = {8{cfg.idle_nibble}};

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[MAX_DELAY-1:0], tx_in.valid & cfg.enable};
      end
   end

   // Stage 0 is the input register, stages 1 and up form the delay line
   always_ff @(posedge clk) begin
      data_q[0] <= in_word;
      for (int i = 1; i < DEPTH; i++) begin
         data_q[i] <= data_q[i-1];
      end
   end

   always_comb begin
      out_valid     = cfg.enable & vld_q[tap];
      tx_out.valid  = out_valid;
      tx_out.data   = out_valid ? data_q[tap] : idle_word;
   end

   // Nothing may leave once every in-flight stage entered while disabled
   a_no_valid_when_disabled: assert property (
      @(posedge clk) disable iff (!reset_n)
      (!cfg.enable) [*DEPTH] |=> (vld_q == '0));

endmodule

`default_nettype wire

// ==== aib_adapt_rx.sv ====
// Receive adapter, pad word to core word
// Optional inversion and left rotation by whole bytes, then a tapped
// delay line; data is held at zero whenever no valid beat is out
`default_nettype none

module aib_adapt_rx #(
   parameter int MAX_DELAY = 7
) (
   input  wire logic                      clk,
   input  wire logic                      reset_n,
   input  wire aib_adapt_pkg::rx_cfg_t    cfg,
   input  wire aib_adapt_pkg::lane_beat_t rx_in,
   output aib_adapt_pkg::lane_beat_t      rx_out
);

   localparam int DEPTH = MAX_DELAY + 1;

   aib_adapt_pkg::lane_word_t inv_word;
   aib_adapt_pkg::lane_word_t rot_word;
   aib_adapt_pkg::lane_word_t data_q [DEPTH];
   logic [MAX_DELAY:0]        vld_q;
   aib_adapt_pkg::dly_t       tap;
   logic                      out_valid;

   always_comb begin
      inv_word = cfg.invert ? ~rx_in.data : rx_in.data;
      case (cfg.byte_rotate)
         2'd1:    rot_word = {inv_word[23:0], inv_word[31:24]};
         2'd2:    rot_word = {inv_word[15:0], inv_word[31:16]};
         2'd3:    rot_word = {inv_word[7:0],  inv_word[31:8]};
         default: rot_word = inv_word;
      endcase
   end

   assign tap = (cfg.delay > MAX_DELAY) ? aib_adapt_pkg::dly_t'(MAX_DELAY) : cfg.delay;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[MAX_DELAY-1:0], rx_in.valid & cfg.enable};
      end
   end

   always_ff @(posedge clk) begin
      data_q[0] <= rot_word;
      for (int i = 1; i < DEPTH; i++) begin
         data_q[i] <= data_q[i-1];
      end
   end

   // Core side sees zero data outside valid beats
   always_comb begin
      out_valid    = cfg.enable & vld_q[tap];
      rx_out.valid = out_valid;
      rx_out.data  = out_valid ? data_q[tap] : '0;
   end

   a_zero_data_when_idle: assert property (
      @(posedge clk) disable iff (!reset_n)
      !rx_out.valid |-> (rx_out.data == '0));

endmodule

`default_nettype wire

// ==== aib_adapt_channel.sv ====
// Adapter channel top level
// Register block driving the transmit and receive adapters
`default_nettype none

module aib_adapt_channel #(
   parameter int MAX_DELAY = 7
) (
   input  wire logic                      clk,
   input  wire logic                      reset_n,
   input  wire aib_adapt_pkg::csr_addr_t  address,
   input  wire aib_adapt_pkg::csr_data_t  writedata,
   input  wire aib_adapt_pkg::byte_en_t   byteenable,
   input  wire logic                      read,
   input  wire logic                      write,
   output wire aib_adapt_pkg::csr_data_t  readdata,
   output wire logic                      readdatavalid,
   input  wire aib_adapt_pkg::lane_beat_t tx_in,
   output wire aib_adapt_pkg::lane_beat_t tx_out,
   input  wire aib_adapt_pkg::lane_beat_t rx_in,
   output wire aib_adapt_pkg::lane_beat_t rx_out
);

   wire aib_adapt_pkg::tx_cfg_t tx_cfg;
   wire aib_adapt_pkg::rx_cfg_t rx_cfg;

   aib_avmm_adapt_csr i_aib_avmm_adapt_csr (
      .clk           (clk),
      .reset_n       (reset_n),
      .address       (address),
      .writedata     (writedata),
      .byteenable    (byteenable),
      .read          (read),
      .write         (write),
      .readdata      (readdata),
      .readdatavalid (readdatavalid),
      .tx_cfg        (tx_cfg),
      .rx_cfg        (rx_cfg)
   );

   // Core to pad
   aib_adapt_tx #(
      .MAX_DELAY (MAX_DELAY)
   ) i_aib_adapt_tx (
      .clk     (clk),
      .reset_n (reset_n),
      .cfg     (tx_cfg),
      .tx_in   (tx_in),
      .tx_out  (tx_out)
   );

   // Pad to core
   aib_adapt_rx #(
      .MAX_DELAY (MAX_DELAY)
   ) i_aib_adapt_rx (
      .clk     (clk),
      .reset_n (reset_n),
      .cfg     (rx_cfg),
      .rx_in   (rx_in),
      .rx_out  (rx_out)
   );

endmodule

`default_nettype wire

// ==== tb_aib_adapt_channel.sv ====
// Testbench for the adapter channel
// Random register traffic and stream beats, checked against a reference model
`default_nettype none

module tb_aib_adapt_channel;

   localparam int MAX_DELAY     = 7;
   localparam int IDX_RX_0      = 0;
   localparam int IDX_RX_1      = 1;
   localparam int IDX_TX_0      = 2;
   localparam int IDX_TX_1      = 3;
   localparam int DRAIN_TIMEOUT = 4 * (MAX_DELAY + 1);

   typedef struct packed {
      logic [31:0]               due;
      aib_adapt_pkg::lane_word_t data;
   } exp_beat_t;

   logic                       clk;
   logic                       reset_n;
   aib_adapt_pkg::csr_addr_t   address;
   aib_adapt_pkg::csr_data_t   writedata;
   aib_adapt_pkg::byte_en_t    byteenable;
   logic                       read;
   logic                       write;
   aib_adapt_pkg::csr_data_t   readdata;
   logic                       readdatavalid;
   aib_adapt_pkg::lane_beat_t  tx_in;
   aib_adapt_pkg::lane_beat_t  tx_out;
   aib_adapt_pkg::lane_beat_t  rx_in;
   aib_adapt_pkg::lane_beat_t  rx_out;

   // Reference model state
   aib_adapt_pkg::csr_data_t   shadow [4];
   exp_beat_t                  tx_exp [$];
   exp_beat_t                  rx_exp [$];
   logic                       rd_expect;
   aib_adapt_pkg::csr_data_t   rd_exp_data;
   int                         cyc;
   integer                     seed;

   aib_adapt_channel #(
      .MAX_DELAY (MAX_DELAY)
   ) i_aib_adapt_channel (
      .clk           (clk),
      .reset_n       (reset_n),
      .address       (address),
      .writedata     (writedata),
      .byteenable    (byteenable),
      .read          (read),
      .write         (write),
      .readdata      (readdata),
      .readdatavalid (readdatavalid),
      .tx_in         (tx_in),
      .tx_out        (tx_out),
      .rx_in         (rx_in),
      .rx_out        (rx_out)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic int reg_index(input aib_adapt_pkg::csr_addr_t a);
      if (a == aib_adapt_pkg::ADDR_RX_0) return IDX_RX_0;
      if (a == aib_adapt_pkg::ADDR_RX_1) return IDX_RX_1;
      if (a == aib_adapt_pkg::ADDR_TX_0) return IDX_TX_0;
      if (a == aib_adapt_pkg::ADDR_TX_1) return IDX_TX_1;
      return -1;
   endfunction

   function automatic aib_adapt_pkg::csr_data_t read_mask(input int idx);
      case (idx)
         IDX_RX_0: return aib_adapt_pkg::RD_MASK_RX_0;
         IDX_RX_1: return aib_adapt_pkg::RD_MASK_RX_1;
         IDX_TX_0: return aib_adapt_pkg::RD_MASK_TX_0;
         default:  return aib_adapt_pkg::RD_MASK_TX_1;
      endcase
   endfunction

   function automatic aib_adapt_pkg::lane_word_t idle_word();
      return {8{shadow[IDX_TX_0][aib_adapt_pkg::TX0_IDLE_LSB +: 4]}};
   endfunction

   // Core to pad word: invert first, then mirror bit order
   function automatic aib_adapt_pkg::lane_word_t tx_model(input aib_adapt_pkg::lane_word_t w);
      aib_adapt_pkg::lane_word_t v;
      aib_adapt_pkg::lane_word_t r;
      v = shadow[IDX_TX_1][aib_adapt_pkg::TX1_INVERT_BIT] ? ~w : w;
      r = v;
      if (shadow[IDX_TX_1][aib_adapt_pkg::TX1_REVERSE_BIT]) begin
         for (int i = 0; i < 32; i++) begin
            r[i] = v[31-i];
         end
      end
      return r;
   endfunction

   // Pad to core word: invert first, then rotate left by whole bytes
   function automatic aib_adapt_pkg::lane_word_t rx_model(input aib_adapt_pkg::lane_word_t w);
      aib_adapt_pkg::lane_word_t v;
      int n;
      v = shadow[IDX_RX_1][aib_adapt_pkg::RX1_INVERT_BIT] ? ~w : w;
      n = shadow[IDX_RX_1][aib_adapt_pkg::RX1_ROTATE_LSB +: 2];
      for (int i = 0; i < n; i++) begin
         v = (v << 8) | (v >> 24);
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // One cycle: sample all outputs at the falling edge, before new inputs are driven
   task automatic tick();
      @(negedge clk);
      cyc++;
      check_value("readdatavalid", readdatavalid, rd_expect);
      if (rd_expect) begin
         check_value("readdata", readdata, rd_exp_data);
      end
      rd_expect = 1'b0;
      if (tx_exp.size() > 0 && tx_exp[0].due == cyc) begin
         check_value("tx_out.valid", tx_out.valid, 1'b1);
         check_value("tx_out.data", tx_out.data, tx_exp[0].data);
         void'(tx_exp.pop_front());
      end else begin
         check_value("tx_out.valid", tx_out.valid, 1'b0);
         check_value("tx_out.data", tx_out.data, idle_word());
      end
      if (rx_exp.size() > 0 && rx_exp[0].due == cyc) begin
         check_value("rx_out.valid", rx_out.valid, 1'b1);
         check_value("rx_out.data", rx_out.data, rx_exp[0].data);
         void'(rx_exp.pop_front());
      end else begin
         check_value("rx_out.valid", rx_out.valid, 1'b0);
         check_value("rx_out.data", rx_out.data, 32'h0);
      end
   endtask

   task automatic write_reg(input aib_adapt_pkg::csr_addr_t a,
                            input aib_adapt_pkg::csr_data_t d,
                            input aib_adapt_pkg::byte_en_t be);
      aib_adapt_pkg::csr_data_t lanes;
      int idx;
      // Byte lane 3 only owns the top nibble
      for (int i = 0; i < 32; i++) begin
         lanes[i] = be[i / 8] && !(i >= 24 && i < 28);
      end
      idx = reg_index(a);
      address    = a;
      writedata  = d;
      byteenable = be;
      write      = 1'b1;
      if (idx >= 0) begin
         shadow[idx] = (shadow[idx] & ~lanes) | (d & lanes);
      end
      tick();
      write = 1'b0;
   endtask

   task automatic read_check(input aib_adapt_pkg::csr_addr_t a);
      int idx;
      idx = reg_index(a);
      address     = a;
      read        = 1'b1;
      rd_expect   = 1'b1;
      rd_exp_data = (idx >= 0) ? (shadow[idx] & read_mask(idx)) : '0;
      tick();
      read = 1'b0;
   endtask

   task automatic program_paths(input logic enable);
      aib_adapt_pkg::csr_data_t v;
      v = $random(seed);
      v[aib_adapt_pkg::CFG_ENABLE_BIT] = enable;
      v[aib_adapt_pkg::TX0_DELAY_LSB +: 3] = {$random(seed)} % (MAX_DELAY + 1);
      write_reg(aib_adapt_pkg::ADDR_TX_0, v, 4'hf);
      v = $random(seed);
      write_reg(aib_adapt_pkg::ADDR_TX_1, v, 4'hf);
      v = $random(seed);
      v[aib_adapt_pkg::CFG_ENABLE_BIT] = enable;
      v[aib_adapt_pkg::RX0_DELAY_LSB +: 3] = {$random(seed)} % (MAX_DELAY + 1);
      write_reg(aib_adapt_pkg::ADDR_RX_0, v, 4'hf);
      v = $random(seed);
      write_reg(aib_adapt_pkg::ADDR_RX_1, v, 4'hf);
      // Let any stale valid bits leave the delay lines
      repeat (MAX_DELAY + 1) tick();
   endtask

   task automatic drive_beats(input int n);
      exp_beat_t beat;
      for (int i = 0; i < n; i++) begin
         tx_in.valid = ($random(seed) & 3) != 0;
         tx_in.data  = $random(seed);
         rx_in.valid = ($random(seed) & 3) != 0;
         rx_in.data  = $random(seed);
         if (tx_in.valid && shadow[IDX_TX_0][aib_adapt_pkg::CFG_ENABLE_BIT]) begin
            beat.due  = cyc + 1 + shadow[IDX_TX_0][aib_adapt_pkg::TX0_DELAY_LSB +: 3];
            beat.data = tx_model(tx_in.data);
            tx_exp.push_back(beat);
         end
         if (rx_in.valid && shadow[IDX_RX_0][aib_adapt_pkg::CFG_ENABLE_BIT]) begin
            beat.due  = cyc + 1 + shadow[IDX_RX_0][aib_adapt_pkg::RX0_DELAY_LSB +: 3];
            beat.data = rx_model(rx_in.data);
            rx_exp.push_back(beat);
         end
         tick();
      end
      tx_in.valid = 1'b0;
      rx_in.valid = 1'b0;
   endtask

   task automatic drain_streams();
      int waited;
      waited = 0;
      while (tx_exp.size() > 0 || rx_exp.size() > 0) begin
         if (waited >= DRAIN_TIMEOUT) begin
            $display("Expected stream beats did not arrive within %0d cycles", DRAIN_TIMEOUT);
            $display("Test failed");
            $fatal(1);
         end
         tick();
         waited++;
      end
      repeat (MAX_DELAY + 1) tick();
   endtask

   initial begin
      aib_adapt_pkg::csr_addr_t a;
      int sel;
      seed       = 32'heeb8;
      reset_n    = 1'b0;
      address    = '0;
      writedata  = '0;
      byteenable = '0;
      read       = 1'b0;
      write      = 1'b0;
      tx_in      = '0;
      rx_in      = '0;
      rd_expect  = 1'b0;
      cyc        = 0;
      for (int i = 0; i < 4; i++) begin
         shadow[i] = '0;
      end
      repeat (8) tick();
      reset_n = 1'b1;

      // Reset values
      read_check(aib_adapt_pkg::ADDR_RX_0);
      read_check(aib_adapt_pkg::ADDR_RX_1);
      read_check(aib_adapt_pkg::ADDR_TX_0);
      read_check(aib_adapt_pkg::ADDR_TX_1);

      // Lane 3 alone on a full pattern
      write_reg(aib_adapt_pkg::ADDR_TX_0, 32'hffff_ffff, 4'h8);
      read_check(aib_adapt_pkg::ADDR_TX_0);

      // Random register traffic, unmapped addresses included
      for (int i = 0; i < 200; i++) begin
         sel = {$random(seed)} % 6;
         case (sel)
            0:       a = aib_adapt_pkg::ADDR_RX_0;
            1:       a = aib_adapt_pkg::ADDR_RX_1;
            2:       a = aib_adapt_pkg::ADDR_TX_0;
            3:       a = aib_adapt_pkg::ADDR_TX_1;
            default: a = $random(seed);
         endcase
         write_reg(a, $random(seed), $random(seed));
         read_check(a);
      end

      // Both data paths under random settings
      for (int i = 0; i < 6; i++) begin
         program_paths(1'b1);
         drive_beats(100);
         drain_streams();
      end

      // Both adapters disabled
      program_paths(1'b0);
      drive_beats(40);
      drain_streams();

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
aib_adapt_pkg.sv
aib_avmm_adapt_csr.sv
aib_adapt_tx.sv
aib_adapt_rx.sv
aib_adapt_channel.sv
tb_aib_adapt_channel.sv
